/* Makefile */
# Verilator lint and simulation of the game view controller

VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_game_view
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* draw_engine.sv */
`timescale 1ns/1ps
// shared sprite draw engine
// sweeps the requested sprite in raster order and pulses its done
module draw_engine
	import view_pkg::*;
(
	input  logic         clk,
	input  logic         resetn,
	input  logic         enable_draw_background,
	input  logic         enable_draw_gold,
	input  logic         enable_draw_stone,
	input  logic         enable_draw_diamond,
	input  logic         enable_draw_hook,
	input  logic         enable_draw_num,
	input  logic         enable_draw_gamestart,
	input  logic         enable_draw_gameover,
	input  logic         enable_draw_game_next_level,
	output logic         draw_background_done,
	output logic         draw_gold_done,
	output logic         draw_stone_done,
	output logic         draw_diamond_done,
	output logic         draw_hook_done,
	output logic         draw_num_done,
	output logic         draw_gamestart_done,
	output logic         draw_gameover_done,
	output logic         draw_game_next_level_done,
	output logic         plot,
	output sprite_kind_t sprite_kind,
	output coord_t       px,
	output coord_t       py
);
	typedef enum logic [1:0] {st_idle, st_sweep, st_rest} engine_state_t;

	engine_state_t state;
	sprite_kind_t req_kind, kind;
	coord_t w, h;
	logic last_pixel;

	// at most one enable is high
	always_comb begin
		req_kind = sk_none;
		if (enable_draw_background)
			req_kind = sk_background;
		else if (enable_draw_gold)
			req_kind = sk_gold;
		else if (enable_draw_stone)
			req_kind = sk_stone;
		else if (enable_draw_diamond)
			req_kind = sk_diamond;
		else if (enable_draw_hook)
			req_kind = sk_hook;
		else if (enable_draw_num)
			req_kind = sk_num;
		else if (enable_draw_gamestart)
			req_kind = sk_banner_start;
		else if (enable_draw_gameover)
			req_kind = sk_banner_over;
		else if (enable_draw_game_next_level)
			req_kind = sk_banner_next;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:  if (req_kind != sk_none) state <= st_sweep;
				st_sweep: if (last_pixel) state <= st_rest;
				// one dead cycle lets the controller drop its enable
				st_rest:  state <= st_idle;
				default:  state <= st_idle;
			endcase
		end
	end

	// latch the request in idle, then step x fastest
	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			kind <= req_kind;
			w <= SPRITE_W[req_kind];
			h <= SPRITE_H[req_kind];
			px <= '0;
			py <= '0;
		end else if (state == st_sweep) begin
			if (px == w - 1'b1) begin
				px <= '0;
				py <= py + 1'b1;
			end else begin
				px <= px + 1'b1;
			end
		end
	end

	assign last_pixel  = (state == st_sweep) && (px == w - 1'b1) && (py == h - 1'b1);
	assign plot        = (state == st_sweep);
	assign sprite_kind = plot ? kind : sk_none;

	assign draw_background_done      = last_pixel && (kind == sk_background);
	assign draw_gold_done            = last_pixel && (kind == sk_gold);
	assign draw_stone_done           = last_pixel && (kind == sk_stone);
	assign draw_diamond_done         = last_pixel && (kind == sk_diamond);
	assign draw_hook_done            = last_pixel && (kind == sk_hook);
	assign draw_num_done             = last_pixel && (kind == sk_num);
	assign draw_gamestart_done       = last_pixel && (kind == sk_banner_start);
	assign draw_gameover_done        = last_pixel && (kind == sk_banner_over);
	assign draw_game_next_level_done = last_pixel && (kind == sk_banner_next);

endmodule

/* field_stock.sv */
`timescale 1ns/1ps
// field object stock
// counts objects drawn this frame, holds the level and its object maxima
module field_stock
	import view_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  logic   resetn_gold_stone_diamond,
	input  logic   level_up,
	input  logic   draw_gold_done,
	input  logic   draw_stone_done,
	input  logic   draw_diamond_done,
	output count_t gold_count,
	output count_t stone_count,
	output count_t diamond_count,
	output max_t   max_gold,
	output max_t   max_stone,
	output max_t   max_diamond,
	output level_t level
);

	always_ff @(posedge clk) begin
		if (!resetn || !resetn_gold_stone_diamond) begin
			gold_count <= '0;
			stone_count <= '0;
			diamond_count <= '0;
		end else begin
			if (draw_gold_done)
				gold_count <= gold_count + 1'b1;
			if (draw_stone_done)
				stone_count <= stone_count + 1'b1;
			if (draw_diamond_done)
				diamond_count <= diamond_count + 1'b1;
		end
	end

	// level saturates at its top value
	always_ff @(posedge clk) begin
		if (!resetn)
			level <= '0;
		else if (level_up && level != '1)
			level <= level + 1'b1;
	end

	assign max_gold    = MAX_GOLD_BASE + max_t'(level);
	assign max_stone   = MAX_STONE_FIXED;
	assign max_diamond = MAX_DIAMOND_BASE + max_t'(level);

endmodule

/* frame_divider.sv */
`timescale 1ns/1ps
// frame tick divider, one-cycle pulse every FRAME_DIV clocks
module frame_divider #(
	parameter int FRAME_DIV = 16
) (
	input  logic clk,
	input  logic resetn,
	output logic frame
);
	localparam int DIV_W = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

	logic [DIV_W-1:0] count;

	// reload on zero
	always_ff @(posedge clk) begin
		if (!resetn || count == '0)
			count <= DIV_W'(FRAME_DIV - 1);
		else
			count <= count - 1'b1;
	end

	assign frame = (count == '0);

endmodule

/* game_view_fsm.sv */
`timescale 1ns/1ps
// game view controller
// walks the screens: banners, background, objects, hook, score and play
module game_view_fsm
	import view_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  logic   go,
	input  logic   frame,
	input  logic   game_end,
	input  logic   next_level,
	input  logic   draw_background_done,
	input  logic   draw_gold_done,
	input  logic   draw_stone_done,
	input  logic   draw_diamond_done,
	input  logic   draw_hook_done,
	input  logic   draw_num_done,
	input  logic   draw_gamestart_done,
	input  logic   draw_gameover_done,
	input  logic   draw_game_next_level_done,
	input  count_t gold_count,
	input  count_t stone_count,
	input  count_t diamond_count,
	input  max_t   max_gold,
	input  max_t   max_stone,
	input  max_t   max_diamond,
	output logic   enable_draw_background,
	output logic   enable_draw_gold,
	output logic   enable_draw_stone,
	output logic   enable_draw_diamond,
	output logic   enable_draw_hook,
	output logic   enable_draw_num,
	output logic   enable_draw_gamestart,
	output logic   enable_draw_gameover,
	output logic   enable_draw_game_next_level,
	output logic   enable_random,
	output logic   timer_enable,
	output logic   time_resetn,
	output logic   resetn_rope,
	output logic   resetn_gold_stone_diamond,
	output logic   level_up
);
	typedef enum logic [4:0] {
		st_start, st_draw_gamestart, st_gamestart_wait, st_generate,
		st_draw_background, st_object_select, st_draw_gold, st_draw_stone,
		st_draw_diamond, st_object_done, st_draw_hook, st_hook_wait, st_draw_num,
		st_game, st_draw_gameover, st_draw_next_level, st_over_press,
		st_over_release, st_next_press, st_level_up
	} view_state_t;

	view_state_t state, next_state;
	logic gold_full, stone_full, diamond_full;

	assign gold_full    = gold_count >= count_t'(max_gold);
	assign stone_full   = stone_count >= count_t'(max_stone);
	assign diamond_full = diamond_count >= count_t'(max_diamond);

	always_comb begin
		next_state = state;
		case (state)
			st_start:           next_state = st_draw_gamestart;
			st_draw_gamestart:  next_state = st_gamestart_wait;
			st_gamestart_wait:  if (draw_gamestart_done) next_state = st_generate;
			st_generate:        if (go) next_state = st_draw_background;
			st_draw_background: if (draw_background_done) next_state = st_object_select;
			// gold first, then stone, then diamond, then the hook
			st_object_select: begin
				if (!gold_full)
					next_state = st_draw_gold;
				else if (!stone_full)
					next_state = st_draw_stone;
				else if (!diamond_full)
					next_state = st_draw_diamond;
				else
					next_state = st_draw_hook;
			end
			st_draw_gold:       if (draw_gold_done) next_state = st_object_done;
			st_draw_stone:      if (draw_stone_done) next_state = st_object_done;
			st_draw_diamond:    if (draw_diamond_done) next_state = st_object_done;
			st_object_done:     next_state = st_object_select;
			st_draw_hook:       next_state = st_hook_wait;
			st_hook_wait:       if (draw_hook_done) next_state = st_draw_num;
			st_draw_num:        if (draw_num_done) next_state = st_game;
			st_game: begin
				if (game_end)
					next_state = next_level ? st_draw_next_level : st_draw_gameover;
				else if (frame)
					next_state = st_draw_background;
			end
			st_draw_gameover:   if (draw_gameover_done) next_state = st_over_press;
			st_draw_next_level: if (draw_game_next_level_done) next_state = st_next_press;
			st_over_press:      if (go) next_state = st_over_release;
			st_over_release:    if (!go) next_state = st_draw_gamestart;
			st_next_press:      if (go) next_state = st_level_up;
			st_level_up:        next_state = st_draw_background;
			default:            next_state = st_start;
		endcase
	end

	always_comb begin
		enable_draw_background      = 1'b0;
		enable_draw_gold            = 1'b0;
		enable_draw_stone           = 1'b0;
		enable_draw_diamond         = 1'b0;
		enable_draw_hook            = 1'b0;
		enable_draw_num             = 1'b0;
		enable_draw_gamestart       = 1'b0;
		enable_draw_gameover        = 1'b0;
		enable_draw_game_next_level = 1'b0;
		enable_random               = 1'b0;
		timer_enable                = 1'b0;
		time_resetn                 = 1'b1;
		resetn_rope                 = 1'b1;
		resetn_gold_stone_diamond   = 1'b1;
		level_up                    = 1'b0;
		case (state)
			st_draw_gamestart, st_gamestart_wait: begin
				enable_draw_gamestart = 1'b1;
				resetn_rope = 1'b0;
			end
			// placement is randomised while waiting for go
			st_generate: begin
				enable_random = 1'b1;
				time_resetn = 1'b0;
				resetn_rope = 1'b0;
			end
			st_draw_background: begin
				enable_draw_background = 1'b1;
				timer_enable = 1'b1;
			end
			st_draw_gold: begin
				enable_draw_gold = 1'b1;
				timer_enable = 1'b1;
			end
			st_draw_stone: begin
				enable_draw_stone = 1'b1;
				timer_enable = 1'b1;
			end
			st_draw_diamond: begin
				enable_draw_diamond = 1'b1;
				timer_enable = 1'b1;
			end
			st_draw_hook, st_hook_wait: begin
				enable_draw_hook = 1'b1;
				timer_enable = 1'b1;
			end
			st_draw_num: begin
				enable_draw_num = 1'b1;
				timer_enable = 1'b1;
			end
			st_object_select, st_object_done: timer_enable = 1'b1;
			// counts clear so the next frame redraws every object
			st_game: begin
				timer_enable = 1'b1;
				resetn_gold_stone_diamond = 1'b0;
			end
			st_draw_gameover:   enable_draw_gameover = 1'b1;
			st_draw_next_level: enable_draw_game_next_level = 1'b1;
			st_over_press, st_over_release, st_next_press: begin
				time_resetn = 1'b0;
				resetn_rope = 1'b0;
				resetn_gold_stone_diamond = 1'b0;
			end
			st_level_up: level_up = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= st_start;
		else
			state <= next_state;
	end

endmodule

/* game_view_top.sv */
`timescale 1ns/1ps
// game view top level
// controller FSM with draw engine, object stock, round timer and frame tick
module game_view_top
	import view_pkg::*;
#(
	parameter int FRAME_DIV    = 16,
	parameter int ROUND_FRAMES = 3,
	parameter int SCORE_TARGET = 100
) (
	input  logic         clk,
	input  logic         resetn,
	input  logic         go,
	input  score_t       score,
	output logic         plot,
	output sprite_kind_t sprite_kind,
	output coord_t       px,
	output coord_t       py,
	output logic         enable_random,
	output logic         resetn_rope,
	output level_t       level
);
	// draw requests and completions
	logic enable_draw_background, enable_draw_gold, enable_draw_stone;
	logic enable_draw_diamond, enable_draw_hook, enable_draw_num;
	logic enable_draw_gamestart, enable_draw_gameover, enable_draw_game_next_level;
	logic draw_background_done, draw_gold_done, draw_stone_done;
	logic draw_diamond_done, draw_hook_done, draw_num_done;
	logic draw_gamestart_done, draw_gameover_done, draw_game_next_level_done;

	// stock, timer and tick
	count_t gold_count, stone_count, diamond_count;
	max_t max_gold, max_stone, max_diamond;
	logic frame, game_end, next_level;
	logic timer_enable, time_resetn, resetn_gold_stone_diamond, level_up;

	game_view_fsm i_fsm (.*);

	frame_divider #(
		.FRAME_DIV(FRAME_DIV)
	) i_frame_divider (.*);

	draw_engine i_draw_engine (.*);

	field_stock i_field_stock (.*);

	round_timer #(
		.ROUND_FRAMES(ROUND_FRAMES),
		.SCORE_TARGET(SCORE_TARGET)
	) i_round_timer (.*);

endmodule

/* project.f */
view_pkg.sv
frame_divider.sv
draw_engine.sv
field_stock.sv
round_timer.sv
game_view_fsm.sv
game_view_top.sv
tb_game_view.sv

/* round_timer.sv */
`timescale 1ns/1ps
// round timer, ends the round after ROUND_FRAMES frame ticks
// and compares the score with the level target
module round_timer
	import view_pkg::*;
#(
	parameter int ROUND_FRAMES = 3,
	parameter int SCORE_TARGET = 100
) (
	input  logic   clk,
	input  logic   resetn,
	input  logic   time_resetn,
	input  logic   timer_enable,
	input  logic   frame,
	input  score_t score,
	output logic   game_end,
	output logic   next_level
);
	localparam int CNT_W = $clog2(ROUND_FRAMES + 1);

	logic [CNT_W-1:0] frame_count;

	// holds at ROUND_FRAMES until cleared
	always_ff @(posedge clk) begin
		if (!resetn || !time_resetn)
			frame_count <= '0;
		else if (timer_enable && frame && !game_end)
			frame_count <= frame_count + 1'b1;
	end

	assign game_end   = (frame_count == CNT_W'(ROUND_FRAMES));
	assign next_level = (score >= score_t'(SCORE_TARGET));

endmodule

/* tb_game_view.sv */
`timescale 1ns/1ps
// game view testbench
// follows the sprite run stream through start, play, game over and next level
module tb_game_view
	import view_pkg::*;
();
	localparam int FRAME_DIV    = 16;
	localparam int ROUND_FRAMES = 3;
	localparam int SCORE_TARGET = 100;
	localparam int NUM_ROUNDS   = 3;

	typedef struct packed {
		sprite_kind_t kind;
		logic [15:0]  pixels;
	} run_t;

	logic         clk;
	logic         resetn;
	logic         go;
	score_t       score;
	logic         plot;
	sprite_kind_t sprite_kind;
	coord_t       px;
	coord_t       py;
	logic         enable_random;
	logic         resetn_rope;
	level_t       level;

	run_t   exp_q[$];
	run_t   obs_q[$];
	run_t   cur_run;
	logic   run_open;
	int     raster_w;
	int     error_count;
	int     check_count;
	int     cycles;
	int     cycle_limit;
	integer seed;
	string  test_name;

	game_view_top #(
		.FRAME_DIV(FRAME_DIV),
		.ROUND_FRAMES(ROUND_FRAMES),
		.SCORE_TARGET(SCORE_TARGET)
	) i_game_view_top (.*);

	always #5 clk = ~clk;

	// expected run order of one frame by the object maxima rule
	function automatic sprite_kind_t expected_kind(input int lvl, input int idx);
		int n_gold;
		int n_stone;
		int n_diamond;
		int i;
		n_gold = int'(MAX_GOLD_BASE) + lvl;
		n_stone = int'(MAX_STONE_FIXED);
		n_diamond = int'(MAX_DIAMOND_BASE) + lvl;
		i = idx;
		if (i == 0)
			return sk_background;
		i = i - 1;
		if (i < n_gold)
			return sk_gold;
		i = i - n_gold;
		if (i < n_stone)
			return sk_stone;
		i = i - n_stone;
		if (i < n_diamond)
			return sk_diamond;
		i = i - n_diamond;
		if (i == 0)
			return sk_hook;
		if (i == 1)
			return sk_num;
		return sk_none;
	endfunction

	function automatic run_t make_run(input sprite_kind_t k);
		run_t r;
		r.kind = k;
		r.pixels = 16'(int'(SPRITE_W[k]) * int'(SPRITE_H[k]));
		return r;
	endfunction

	// pixels plus latch, rest and a couple of controller steps
	function automatic int sprite_cost(input sprite_kind_t k);
		return int'(SPRITE_W[k]) * int'(SPRITE_H[k]) + 4;
	endfunction

	function automatic int frame_cost(input int lvl);
		int idx;
		int total;
		idx = 0;
		total = 0;
		while (expected_kind(lvl, idx) != sk_none) begin
			total += sprite_cost(expected_kind(lvl, idx));
			idx++;
		end
		return total;
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		check_count++;
		if (expected != actual) begin
			error_count++;
			$display("mismatch %s %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
		end
	endtask

	task automatic press_go();
		int hold;
		hold = 1 + ($random(seed) & 3);
		@(posedge clk);
		go <= 1'b1;
		repeat (hold) @(posedge clk);
		go <= 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic wait_run();
		while (obs_q.size() == 0)
			@(posedge clk);
	endtask

	task automatic push_frame(input int lvl);
		int idx;
		idx = 0;
		while (expected_kind(lvl, idx) != sk_none) begin
			exp_q.push_back(make_run(expected_kind(lvl, idx)));
			idx++;
		end
	endtask

	// wait for placement and press go into the first frame
	task automatic start_game();
		while (!enable_random)
			@(posedge clk);
		check_value("resetn_rope while waiting", 0, int'(resetn_rope));
		drain();
		press_go();
		@(posedge clk);
		check_value("enable_random after go", 0, int'(enable_random));
		check_value("resetn_rope after go", 1, int'(resetn_rope));
	endtask

	// frames repeat until the round ends in a banner
	task automatic play_round(input int lvl, input sprite_kind_t banner);
		int frames;
		push_frame(lvl);
		drain();
		frames = 1;
		wait_run();
		while (obs_q[0].kind == sk_background && frames < ROUND_FRAMES) begin
			push_frame(lvl);
			drain();
			frames++;
			wait_run();
		end
		exp_q.push_back(make_run(banner));
		drain();
	endtask

	// cut the plot stream into runs and check raster order
	always @(posedge clk) begin
		if (!resetn) begin
			run_open = 1'b0;
		end else begin
			if (run_open && (!plot || sprite_kind != cur_run.kind)) begin
				obs_q.push_back(cur_run);
				run_open = 1'b0;
			end
			if (plot) begin
				if (!run_open) begin
					cur_run.kind = sprite_kind;
					cur_run.pixels = '0;
					run_open = 1'b1;
				end
				raster_w = int'(SPRITE_W[cur_run.kind]);
				if (raster_w != 0) begin
					check_value("px", int'(cur_run.pixels) % raster_w, int'(px));
					check_value("py", int'(cur_run.pixels) / raster_w, int'(py));
				end
				cur_run.pixels = cur_run.pixels + 16'd1;
			end
		end
	end

	initial begin : compare_runs
		run_t want;
		run_t got;
		forever begin
			while (obs_q.size() == 0 || exp_q.size() == 0)
				@(posedge clk);
			got = obs_q.pop_front();
			want = exp_q.pop_front();
			check_value("run kind", int'(want.kind), int'(got.kind));
			check_value("run pixels", int'(want.pixels), int'(got.pixels));
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: no result after %0d cycles in %s", cycles, test_name);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		go = 1'b0;
		score = '0;
		seed = 32'h34b7_f9e6;
		error_count = 0;
		check_count = 0;
		cycles = 0;
		cycle_limit = 2 * NUM_ROUNDS * (ROUND_FRAMES * (frame_cost(1) + FRAME_DIV)
			+ 2 * sprite_cost(sk_banner_start) + 32);
		test_name = "reset";
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		check_value("plot", 0, int'(plot));
		check_value("enable_random", 0, int'(enable_random));

		// score below target ends in game over
		test_name = "start";
		exp_q.push_back(make_run(sk_banner_start));
		start_game();
		test_name = "round_over";
		play_round(0, sk_banner_over);
		press_go();
		test_name = "restart";
		exp_q.push_back(make_run(sk_banner_start));
		drain();
		check_value("level", 0, int'(level));

		// score at the target ends in the next level banner
		@(posedge clk);
		score <= score_t'(SCORE_TARGET);
		test_name = "round_next";
		start_game();
		play_round(0, sk_banner_next);
		press_go();
		repeat (2) @(posedge clk);
		test_name = "level1";
		check_value("level", 1, int'(level));
		play_round(1, sk_banner_next);

		repeat (4) @(posedge clk);
		if (obs_q.size() != 0 || run_open || plot) begin
			error_count++;
			$display("error: sprite output continued after the last expected run");
		end
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* view_pkg.sv */
// view controller shared definitions
// sprite kinds, datapath widths, sprite sizes and per-level object maxima
package view_pkg;

	typedef enum logic [3:0] {
		sk_none,
		sk_background,
		sk_gold,
		sk_stone,
		sk_diamond,
		sk_hook,
		sk_num,
		sk_banner_start,
		sk_banner_over,
		sk_banner_next
	} sprite_kind_t;

	typedef logic [7:0] coord_t;
	typedef logic [7:0] count_t;
	typedef logic [4:0] max_t;
	typedef logic [3:0] level_t;
	typedef logic [9:0] score_t;

	// sprite sizes in pixels, small to keep sweeps short
	localparam coord_t BACKGROUND_W   = 8'd8;
	localparam coord_t BACKGROUND_H   = 8'd6;
	localparam coord_t GOLD_W         = 8'd4;
	localparam coord_t GOLD_H         = 8'd3;
	localparam coord_t STONE_W        = 8'd3;
	localparam coord_t STONE_H        = 8'd3;
	localparam coord_t DIAMOND_W      = 8'd2;
	localparam coord_t DIAMOND_H      = 8'd2;
	localparam coord_t HOOK_W         = 8'd2;
	localparam coord_t HOOK_H         = 8'd3;
	localparam coord_t NUM_W          = 8'd4;
	localparam coord_t NUM_H          = 8'd2;
	localparam coord_t BANNER_START_W = 8'd6;
	localparam coord_t BANNER_START_H = 8'd4;
	localparam coord_t BANNER_OVER_W  = 8'd6;
	localparam coord_t BANNER_OVER_H  = 8'd4;
	localparam coord_t BANNER_NEXT_W  = 8'd6;
	localparam coord_t BANNER_NEXT_H  = 8'd4;

	// size tables in sprite kind order
	localparam coord_t SPRITE_W [10] = '{
		8'd0, BACKGROUND_W, GOLD_W, STONE_W, DIAMOND_W, HOOK_W, NUM_W,
		BANNER_START_W, BANNER_OVER_W, BANNER_NEXT_W
	};
	localparam coord_t SPRITE_H [10] = '{
		8'd0, BACKGROUND_H, GOLD_H, STONE_H, DIAMOND_H, HOOK_H, NUM_H,
		BANNER_START_H, BANNER_OVER_H, BANNER_NEXT_H
	};

	// object maxima per level
	localparam max_t MAX_GOLD_BASE    = 5'd2;   // plus the level
	localparam max_t MAX_STONE_FIXED  = 5'd3;
	localparam max_t MAX_DIAMOND_BASE = 5'd1;   // plus the level

endpackage
